// ==== rtl/cluster_bus_pkg.sv ====
// Core data bus widths, cluster address map, target select and event-unit register offsets
`default_nettype none

package cluster_bus_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // The upper address bits select a 4 MiB window and the lower bits give the offset inside it
  localparam int unsigned PAGE_WIDTH   = 10;
  localparam int unsigned OFFSET_WIDTH = ADDR_WIDTH - PAGE_WIDTH;

  // Shared alias window at 0x1000_0000
  localparam logic [PAGE_WIDTH-1:0] TCDM_ALIAS_PAGE   = 10'h040;
  // Cluster 0 has its global window at 0x1040_0000 and cluster n sits n windows higher
  localparam logic [PAGE_WIDTH-1:0] CLUSTER_PAGE_BASE = 10'h041;

  localparam logic [OFFSET_WIDTH-1:0] TCDM_OFFSET_LIMIT = 22'h20_0000;
  localparam logic [OFFSET_WIDTH-1:0] EU_OFFSET_BASE    = 22'h20_0800;
  localparam logic [OFFSET_WIDTH-1:0] EU_OFFSET_SIZE    = 22'h00_0800;

  // Register offset inside the 2 KiB event-unit span
  localparam int unsigned EU_REG_WIDTH = 11;

  typedef enum logic [1:0] {
    TARGET_TCDM   = 2'd0,
    TARGET_EU     = 2'd1,
    TARGET_PERIPH = 2'd2
  } target_e;

  typedef enum logic [EU_REG_WIDTH-1:0] {
    EU_MASK   = 11'h000,
    EU_BUFFER = 11'h004,
    EU_SET    = 11'h008,
    EU_CLEAR  = 11'h00C,
    EU_MASKED = 11'h010
  } eu_reg_e;

endpackage

`default_nettype wire

// ==== rtl/cluster_core_assist.sv ====
// Core assist block: data bus demux, peripheral port breakout and performance event pulses
`timescale 1ns/1ps
`default_nettype none

module cluster_core_assist
  import cluster_bus_pkg::*;
  import cluster_perf_pkg::*;
#(
  parameter int unsigned OUTSTANDING_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [5:0]               cluster_id_i,
  core_data_if.slave               core,
  core_data_if.master              tcdm,
  core_data_if.master              eu,
  output logic                     periph_req_o,
  output logic [ADDR_WIDTH-1:0]    periph_add_o,
  output logic                     periph_wen_o,
  output logic [DATA_WIDTH-1:0]    periph_wdata_o,
  output logic [BE_WIDTH-1:0]      periph_be_o,
  input  logic                     periph_gnt_i,
  input  logic                     periph_r_valid_i,
  input  logic [DATA_WIDTH-1:0]    periph_r_rdata_i,
  input  logic                     periph_r_opc_i,
  output logic [N_PERF_EVENTS-1:0] perf_counters_o
);

  localparam int unsigned PTR_W = (OUTSTANDING_DEPTH > 1) ? $clog2(OUTSTANDING_DEPTH) : 1;

  target_e                      resp_target;
  logic                         pending;
  logic                         periph_push;
  logic                         periph_pop;
  logic [OUTSTANDING_DEPTH-1:0] is_load_q;
  logic [OUTSTANDING_DEPTH-1:0] valid_q;
  logic [PTR_W-1:0]             wr_ptr_q;
  logic [PTR_W-1:0]             rd_ptr_q;

  core_data_if periph_bus ();

  core_demux #(
    .OUTSTANDING_DEPTH(OUTSTANDING_DEPTH)
  ) u_core_demux (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cluster_id_i (cluster_id_i),
    .core         (core),
    .tcdm         (tcdm),
    .eu           (eu),
    .periph       (periph_bus),
    .resp_target_o(resp_target),
    .pending_o    (pending)
  );

  assign periph_req_o   = periph_bus.req;
  assign periph_add_o   = periph_bus.add;
  assign periph_wen_o   = periph_bus.wen;
  assign periph_wdata_o = periph_bus.wdata;
  assign periph_be_o    = periph_bus.be;

  assign periph_bus.gnt     = periph_gnt_i;
  assign periph_bus.r_valid = periph_r_valid_i;
  assign periph_bus.r_rdata = periph_r_rdata_i;
  assign periph_bus.r_opc   = periph_r_opc_i;

  assign periph_push = periph_bus.req && periph_gnt_i;
  // The demux only retires a peripheral response when the peripheral is at its head
  assign periph_pop  = periph_r_valid_i && pending && (resp_target == TARGET_PERIPH);

  // One load/store bit per peripheral access between grant and response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (periph_pop) begin
        valid_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q          <= (rd_ptr_q == PTR_W'(OUTSTANDING_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (periph_push) begin
        valid_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q          <= (wr_ptr_q == PTR_W'(OUTSTANDING_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (periph_push) begin
      is_load_q[wr_ptr_q] <= periph_bus.wen;
    end
  end

  assign perf_counters_o[PERF_L2_LD]     = periph_push && periph_bus.wen;
  assign perf_counters_o[PERF_L2_ST]     = periph_push && !periph_bus.wen;
  // Outstanding from the cycle after the grant up to and including the response cycle
  assign perf_counters_o[PERF_L2_LD_CYC] = |(valid_q & is_load_q);
  assign perf_counters_o[PERF_L2_ST_CYC] = |(valid_q & ~is_load_q);
  assign perf_counters_o[PERF_TCDM_CONT] = tcdm.req && !tcdm.gnt;

endmodule

`default_nettype wire

// ==== rtl/cluster_data_top.sv ====
// Cluster data-side top level: core assist, scratchpad and event-unit registers
`timescale 1ns/1ps
`default_nettype none

module cluster_data_top
  import cluster_bus_pkg::*;
  import cluster_perf_pkg::*;
#(
  parameter int unsigned TCDM_DEPTH        = 256,
  parameter int unsigned OUTSTANDING_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [5:0]               cluster_id_i,
  input  logic                     core_req_i,
  input  logic [ADDR_WIDTH-1:0]    core_add_i,
  input  logic                     core_wen_i,
  input  logic [DATA_WIDTH-1:0]    core_wdata_i,
  input  logic [BE_WIDTH-1:0]      core_be_i,
  output logic                     core_gnt_o,
  output logic                     core_r_valid_o,
  output logic [DATA_WIDTH-1:0]    core_r_rdata_o,
  output logic                     core_r_opc_o,
  output logic                     periph_req_o,
  output logic [ADDR_WIDTH-1:0]    periph_add_o,
  output logic                     periph_wen_o,
  output logic [DATA_WIDTH-1:0]    periph_wdata_o,
  output logic [BE_WIDTH-1:0]      periph_be_o,
  input  logic                     periph_gnt_i,
  input  logic                     periph_r_valid_i,
  input  logic [DATA_WIDTH-1:0]    periph_r_rdata_i,
  input  logic                     periph_r_opc_i,
  input  logic                     dma_busy_i,
  input  logic [7:0]               evt_i,
  output logic                     evt_pending_o,
  output logic [N_PERF_EVENTS-1:0] perf_counters_o
);

  core_data_if core_bus ();
  core_data_if tcdm_bus ();
  core_data_if eu_bus ();

  assign core_bus.req   = core_req_i;
  assign core_bus.add   = core_add_i;
  assign core_bus.wen   = core_wen_i;
  assign core_bus.wdata = core_wdata_i;
  assign core_bus.be    = core_be_i;

  assign core_gnt_o     = core_bus.gnt;
  assign core_r_valid_o = core_bus.r_valid;
  assign core_r_rdata_o = core_bus.r_rdata;
  assign core_r_opc_o   = core_bus.r_opc;

  cluster_core_assist #(
    .OUTSTANDING_DEPTH(OUTSTANDING_DEPTH)
  ) u_core_assist (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cluster_id_i    (cluster_id_i),
    .core            (core_bus),
    .tcdm            (tcdm_bus),
    .eu              (eu_bus),
    .periph_req_o    (periph_req_o),
    .periph_add_o    (periph_add_o),
    .periph_wen_o    (periph_wen_o),
    .periph_wdata_o  (periph_wdata_o),
    .periph_be_o     (periph_be_o),
    .periph_gnt_i    (periph_gnt_i),
    .periph_r_valid_i(periph_r_valid_i),
    .periph_r_rdata_i(periph_r_rdata_i),
    .periph_r_opc_i  (periph_r_opc_i),
    .perf_counters_o (perf_counters_o)
  );

  tcdm_scratchpad #(
    .TCDM_DEPTH(TCDM_DEPTH)
  ) u_tcdm_scratchpad (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .dma_busy_i(dma_busy_i),
    .bus       (tcdm_bus)
  );

  event_unit_regs u_event_unit_regs (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .evt_i        (evt_i),
    .bus          (eu_bus),
    .evt_pending_o(evt_pending_o)
  );

endmodule

`default_nettype wire

// ==== rtl/cluster_perf_pkg.sv ====
// Performance event bit positions and event count for the core assist block
`default_nettype none

package cluster_perf_pkg;

  localparam int unsigned N_PERF_EVENTS = 5;

  // Each value is the bit index of the pulse in perf_counters_o
  typedef enum logic [2:0] {
    PERF_L2_LD     = 3'd0,
    PERF_L2_ST     = 3'd1,
    PERF_L2_LD_CYC = 3'd2,
    PERF_L2_ST_CYC = 3'd3,
    PERF_TCDM_CONT = 3'd4
  } perf_event_e;

endpackage

`default_nettype wire

// ==== rtl/core_data_if.sv ====
// Request/grant data bus interface with in-order response and master/slave modports
`timescale 1ns/1ps
`default_nettype none

interface core_data_if import cluster_bus_pkg::*; ();

  // The request channel treats wen high as a read
  logic                  req;
  logic [ADDR_WIDTH-1:0] add;
  logic                  wen;
  logic [DATA_WIDTH-1:0] wdata;
  logic [BE_WIDTH-1:0]   be;
  logic                  gnt;

  // On the response channel r_opc high flags an error
  logic                  r_valid;
  logic [DATA_WIDTH-1:0] r_rdata;
  logic                  r_opc;

  modport master (
    output req, add, wen, wdata, be,
    input  gnt, r_valid, r_rdata, r_opc
  );

  modport slave (
    input  req, add, wen, wdata, be,
    output gnt, r_valid, r_rdata, r_opc
  );

endinterface

`default_nettype wire

// ==== rtl/core_demux.sv ====
// Core data bus demux: address decode, target steering and in-order response return
`timescale 1ns/1ps
`default_nettype none

module core_demux import cluster_bus_pkg::*; #(
  parameter int unsigned OUTSTANDING_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic [5:0]  cluster_id_i,
  core_data_if.slave  core,
  core_data_if.master tcdm,
  core_data_if.master eu,
  core_data_if.master periph,
  output target_e     resp_target_o,
  output logic        pending_o
);

  localparam int unsigned PTR_W = (OUTSTANDING_DEPTH > 1) ? $clog2(OUTSTANDING_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(OUTSTANDING_DEPTH + 1);

  logic [PAGE_WIDTH-1:0]   page;
  logic [OFFSET_WIDTH-1:0] offset;
  logic                    in_window;
  target_e                 sel_target;
  logic                    target_gnt;
  logic                    accept;
  logic                    push;
  logic                    pop;
  logic                    head_valid;

  target_e                 queue_q [OUTSTANDING_DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [CNT_W-1:0]        count_q;
  target_e                 last_target_q;

  assign page   = core.add[ADDR_WIDTH-1:OFFSET_WIDTH];
  assign offset = core.add[OFFSET_WIDTH-1:0];

  // Either the shared alias or this cluster's own global window
  assign in_window = (page == TCDM_ALIAS_PAGE) ||
                     (page == CLUSTER_PAGE_BASE + {4'b0, cluster_id_i});

  always_comb begin
    sel_target = TARGET_PERIPH;
    if (in_window) begin
      if (offset < TCDM_OFFSET_LIMIT) begin
        sel_target = TARGET_TCDM;
      end else if (offset >= EU_OFFSET_BASE && offset < EU_OFFSET_BASE + EU_OFFSET_SIZE) begin
        sel_target = TARGET_EU;
      end
    end
  end

  // A new request may only join the youngest pending target, and only with room in the queue
  assign accept = core.req && (count_q != CNT_W'(OUTSTANDING_DEPTH)) &&
                  ((count_q == '0) || (sel_target == last_target_q));

  assign tcdm.req   = accept && (sel_target == TARGET_TCDM);
  assign tcdm.add   = {{PAGE_WIDTH{1'b0}}, offset};
  assign tcdm.wen   = core.wen;
  assign tcdm.wdata = core.wdata;
  assign tcdm.be    = core.be;

  assign eu.req   = accept && (sel_target == TARGET_EU);
  assign eu.add   = {{PAGE_WIDTH{1'b0}}, offset};
  assign eu.wen   = core.wen;
  assign eu.wdata = core.wdata;
  assign eu.be    = core.be;

  // The peripheral port sees the untouched core address
  assign periph.req   = accept && (sel_target == TARGET_PERIPH);
  assign periph.add   = core.add;
  assign periph.wen   = core.wen;
  assign periph.wdata = core.wdata;
  assign periph.be    = core.be;

  always_comb begin
    case (sel_target)
      TARGET_TCDM: target_gnt = tcdm.gnt;
      TARGET_EU:   target_gnt = eu.gnt;
      default:     target_gnt = periph.gnt;
    endcase
  end

  assign core.gnt = accept && target_gnt;
  assign push     = core.req && core.gnt;

  assign resp_target_o = queue_q[rd_ptr_q];
  assign pending_o     = (count_q != '0);

  // Responses are taken only from the target at the head of the queue
  always_comb begin
    head_valid   = 1'b0;
    core.r_rdata = '0;
    core.r_opc   = 1'b0;
    case (resp_target_o)
      TARGET_TCDM: begin
        head_valid   = tcdm.r_valid;
        core.r_rdata = tcdm.r_rdata;
        core.r_opc   = tcdm.r_opc;
      end
      TARGET_EU: begin
        head_valid   = eu.r_valid;
        core.r_rdata = eu.r_rdata;
        core.r_opc   = eu.r_opc;
      end
      default: begin
        head_valid   = periph.r_valid;
        core.r_rdata = periph.r_rdata;
        core.r_opc   = periph.r_opc;
      end
    endcase
  end

  assign pop          = pending_o && head_valid;
  assign core.r_valid = pop;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      count_q       <= '0;
      last_target_q <= TARGET_PERIPH;
    end else begin
      if (push) begin
        wr_ptr_q      <= (wr_ptr_q == PTR_W'(OUTSTANDING_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        last_target_q <= sel_target;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(OUTSTANDING_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= sel_target;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/event_unit_regs.sv ====
// Event-unit register block: mask, event buffer with set and clear, pending flag
`timescale 1ns/1ps
`default_nettype none

module event_unit_regs import cluster_bus_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic [7:0] evt_i,
  core_data_if.slave bus,
  output logic       evt_pending_o
);

  logic [EU_REG_WIDTH-1:0] reg_off;
  logic                    wr_en;
  logic [7:0]              mask_q;
  logic [7:0]              buffer_q;
  logic [7:0]              buffer_d;
  logic [DATA_WIDTH-1:0]   rdata_d;
  logic                    opc_d;
  logic [DATA_WIDTH-1:0]   rdata_q;
  logic                    opc_q;
  logic                    r_valid_q;

  assign bus.gnt = bus.req;
  assign reg_off = bus.add[EU_REG_WIDTH-1:0];
  assign wr_en   = bus.req && !bus.wen;

  // Incoming events first, then a set, then a clear, so a clear wins in the same cycle
  always_comb begin
    buffer_d = buffer_q | evt_i;
    if (wr_en && reg_off == EU_SET) begin
      buffer_d = buffer_d | bus.wdata[7:0];
    end
    if (wr_en && reg_off == EU_CLEAR) begin
      buffer_d = buffer_d & ~bus.wdata[7:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mask_q   <= '0;
      buffer_q <= '0;
    end else begin
      buffer_q <= buffer_d;
      if (wr_en && reg_off == EU_MASK) begin
        mask_q <= bus.wdata[7:0];
      end
    end
  end

  // Read data reflects the registers before this access takes effect
  always_comb begin
    rdata_d = '0;
    opc_d   = 1'b0;
    case (reg_off)
      EU_MASK:   rdata_d = {{(DATA_WIDTH-8){1'b0}}, mask_q};
      EU_BUFFER: rdata_d = {{(DATA_WIDTH-8){1'b0}}, buffer_q};
      EU_MASKED: rdata_d = {{(DATA_WIDTH-8){1'b0}}, buffer_q & mask_q};
      EU_SET, EU_CLEAR: rdata_d = '0;
      default:   opc_d   = 1'b1;
    endcase
    if (!bus.wen) begin
      rdata_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.gnt) begin
      rdata_q <= rdata_d;
      opc_q   <= opc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.gnt;
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = rdata_q;
  assign bus.r_opc   = opc_q;

  assign evt_pending_o = |(buffer_q & mask_q);

endmodule

`default_nettype wire

// ==== rtl/tcdm_scratchpad.sv ====
// Single-port byte-enabled scratchpad memory with a busy input that holds off grants
`timescale 1ns/1ps
`default_nettype none

module tcdm_scratchpad import cluster_bus_pkg::*; #(
  parameter int unsigned TCDM_DEPTH = 256
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       dma_busy_i,
  core_data_if.slave bus
);

  localparam int unsigned IDX_W = (TCDM_DEPTH > 1) ? $clog2(TCDM_DEPTH) : 1;

  logic [DATA_WIDTH-1:0]   mem_q [TCDM_DEPTH];
  logic [ADDR_WIDTH-3:0]   word_addr;
  logic [IDX_W-1:0]        word_idx;
  logic [DATA_WIDTH-1:0]   rdata_q;
  logic                    r_valid_q;

  // Word index wraps at the memory depth
  assign word_addr = bus.add[ADDR_WIDTH-1:2];
  assign word_idx  = IDX_W'(word_addr % (ADDR_WIDTH-2)'(TCDM_DEPTH));

  // Another master owning the memory keeps the core waiting
  assign bus.gnt = bus.req && !dma_busy_i;

  always_ff @(posedge clk_i) begin
    if (bus.gnt && !bus.wen) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (bus.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (bus.gnt) begin
      rdata_q <= bus.wen ? mem_q[word_idx] : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= bus.gnt;
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_rdata = rdata_q;
  assign bus.r_opc   = 1'b0;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_cluster_data_top -f vlog.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q ">>> PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tb/tb_cluster_data_top.sv ====
// Cluster data top testbench with clock, reset, core driver, peripheral responder, model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_cluster_data_top
  import cluster_bus_pkg::*;
  import cluster_perf_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int TCDM_DEPTH   = 256;
  localparam int FILL_WORDS   = 16;
  localparam int N_RANDOM     = 48;
  // Upper bound on the directed accesses issued below
  localparam int N_DIRECTED   = 40;
  localparam int MAX_CYCLES   = 20 * (N_DIRECTED + N_RANDOM) + RESET_CYCLES;

  localparam logic [31:0] ALIAS_BASE = 32'h1000_0000;
  // The DUT runs as cluster 3, whose own window starts here
  localparam logic [31:0] OWN_BASE   = 32'h1100_0000;
  localparam logic [31:0] EU_BASE    = 32'h0020_0800;
  localparam logic [31:0] PERIPH_KEY = 32'hC0DE_5A5A;

  logic                     clk;
  logic                     reset;
  logic                     core_req;
  logic [31:0]              core_add;
  logic                     core_wen;
  logic [31:0]              core_wdata;
  logic [3:0]               core_be;
  logic                     core_gnt;
  logic                     core_r_valid;
  logic [31:0]              core_r_rdata;
  logic                     core_r_opc;
  logic                     periph_req;
  logic [31:0]              periph_add;
  logic                     periph_wen;
  logic [31:0]              periph_wdata;
  logic [3:0]               periph_be;
  logic                     periph_gnt;
  logic                     periph_r_valid;
  logic [31:0]              periph_r_rdata;
  logic                     dma_busy;
  logic [7:0]               evt;
  logic                     evt_pending;
  logic [N_PERF_EVENTS-1:0] perf;

  // Reference model of the scratchpad words, the event-unit registers and the responses in order
  logic [31:0] tcdm_model [TCDM_DEPTH];
  logic [7:0]  eu_mask;
  logic [7:0]  eu_buf;
  logic [31:0] exp_data [$];
  logic        exp_opc [$];
  logic [31:0] resp_addr_q [$];
  logic        resp_rd_q [$];
  logic        periph_out_q [$];
  int          gnt_wait;
  int          resp_wait;
  logic        periph_waiting;
  int          cycles;
  int          ld_pulses;
  int          st_pulses;
  int          ld_grants;
  int          st_grants;
  int          cont_pulses;
  logic        core_local;
  logic        core_tcdm;

  cluster_data_top u_cluster_data_top (
    .clk_i           (clk),
    .reset_i         (reset),
    .cluster_id_i    (6'd3),
    .core_req_i      (core_req),
    .core_add_i      (core_add),
    .core_wen_i      (core_wen),
    .core_wdata_i    (core_wdata),
    .core_be_i       (core_be),
    .core_gnt_o      (core_gnt),
    .core_r_valid_o  (core_r_valid),
    .core_r_rdata_o  (core_r_rdata),
    .core_r_opc_o    (core_r_opc),
    .periph_req_o    (periph_req),
    .periph_add_o    (periph_add),
    .periph_wen_o    (periph_wen),
    .periph_wdata_o  (periph_wdata),
    .periph_be_o     (periph_be),
    .periph_gnt_i    (periph_gnt),
    .periph_r_valid_i(periph_r_valid),
    .periph_r_rdata_i(periph_r_rdata),
    .periph_r_opc_i  (1'b0),
    .dma_busy_i      (dma_busy),
    .evt_i           (evt),
    .evt_pending_o   (evt_pending),
    .perf_counters_o (perf)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // The alias page 0x040 and the own page 0x044 form the windows and the offset picks the target
  function automatic target_e target_of(input logic [31:0] addr);
    if (addr[31:22] != 10'h040 && addr[31:22] != 10'h044) begin
      return TARGET_PERIPH;
    end
    if (addr[21:0] < 22'h20_0000) begin
      return TARGET_TCDM;
    end
    if (addr[21:0] >= 22'h20_0800 && addr[21:0] < 22'h20_1000) begin
      return TARGET_EU;
    end
    return TARGET_PERIPH;
  endfunction

  assign core_local = core_req && (target_of(core_add) != TARGET_PERIPH);
  assign core_tcdm  = core_req && (target_of(core_add) == TARGET_TCDM);

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3C3C_0F0F;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      fail_now($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Applies a granted access to the model and queues the response it must produce
  function automatic void record_expected(input logic [31:0] addr, input logic rd,
                                          input logic [31:0] wdata, input logic [3:0] be);
    logic [31:0] data;
    logic        opc;
    logic [10:0] reg_off;
    int          idx;
    int          b;
    data = '0;
    opc  = 1'b0;
    case (target_of(addr))
      TARGET_TCDM: begin
        idx = int'(addr[21:2]) % TCDM_DEPTH;
        if (rd) begin
          data = tcdm_model[idx];
        end else begin
          for (b = 0; b < 4; b++) begin
            if (be[b]) tcdm_model[idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
      end
      TARGET_EU: begin
        reg_off = addr[10:0];
        case (reg_off)
          EU_MASK:          data = {24'h0, eu_mask};
          EU_BUFFER:        data = {24'h0, eu_buf};
          EU_MASKED:        data = {24'h0, eu_buf & eu_mask};
          EU_SET, EU_CLEAR: data = '0;
          default:          opc = 1'b1;
        endcase
        if (!rd) begin
          data = '0;
          if (reg_off == EU_MASK) eu_mask = wdata[7:0];
          if (reg_off == EU_SET) eu_buf = eu_buf | wdata[7:0];
          if (reg_off == EU_CLEAR) eu_buf = eu_buf & ~wdata[7:0];
        end
      end
      default: begin
        data = rd ? (addr ^ PERIPH_KEY) : '0;
        if (rd) ld_grants++;
        else st_grants++;
      end
    endcase
    exp_data.push_back(data);
    exp_opc.push_back(opc);
  endfunction

  // Called on a falling edge and returns on the falling edge after the grant
  task automatic issue(input logic [31:0] addr, input logic rd, input logic [31:0] wdata,
                       input logic [3:0] be);
    core_req   = 1'b1;
    core_add   = addr;
    core_wen   = rd;
    core_wdata = wdata;
    core_be    = be;
    @(posedge clk);
    while (!core_gnt) @(posedge clk);
    record_expected(addr, rd, wdata, be);
    @(negedge clk);
    core_req = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_data.size() != 0) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic check_pending();
    check_eq("evt_pending_o", 32'(evt_pending), 32'(|(eu_buf & eu_mask)));
  endtask

  // Values read here are the ones settled before the edge
  always @(posedge clk) begin
    logic ld_out;
    logic st_out;
    cycles++;
    if (cycles > MAX_CYCLES) fail_now("Run did not finish within its cycle limit");
    if (!reset) begin
      if (core_r_valid) begin
        if (exp_data.size() == 0) begin
          fail_now("Core response arrived with no access outstanding");
        end else begin
          check_eq("core_r_rdata_o", core_r_rdata, exp_data.pop_front());
          check_eq("core_r_opc_o", 32'(core_r_opc), 32'(exp_opc.pop_front()));
        end
      end
      ld_out = 1'b0;
      st_out = 1'b0;
      foreach (periph_out_q[k]) begin
        if (periph_out_q[k]) ld_out = 1'b1;
        else st_out = 1'b1;
      end
      check_eq("perf_counters_o[PERF_L2_LD_CYC]", 32'(perf[PERF_L2_LD_CYC]), 32'(ld_out));
      check_eq("perf_counters_o[PERF_L2_ST_CYC]", 32'(perf[PERF_L2_ST_CYC]), 32'(st_out));
      if (periph_r_valid) void'(periph_out_q.pop_front());
      if (periph_req && periph_gnt) begin
        check_eq("periph_add_o", periph_add, core_add);
        check_eq("periph_wen_o", 32'(periph_wen), 32'(core_wen));
        check_eq("periph_wdata_o", periph_wdata, core_wdata);
        check_eq("periph_be_o", 32'(periph_be), 32'(core_be));
        periph_out_q.push_back(core_wen);
        resp_addr_q.push_back(periph_add);
        resp_rd_q.push_back(periph_wen);
        gnt_wait = $urandom_range(3, 0);
      end
      periph_waiting = periph_req && !periph_gnt;
      if (perf[PERF_L2_LD]) ld_pulses++;
      if (perf[PERF_L2_ST]) st_pulses++;
      if (perf[PERF_TCDM_CONT]) cont_pulses++;
    end
  end

  // The peripheral slave grants after 0 to 3 waiting cycles and answers in grant order
  always @(negedge clk) begin
    if (!reset) begin
      if (periph_waiting && gnt_wait != 0) gnt_wait = gnt_wait - 1;
      periph_gnt     = (gnt_wait == 0);
      periph_r_valid = 1'b0;
      periph_r_rdata = '0;
      if (resp_addr_q.size() != 0) begin
        if (resp_wait != 0) begin
          resp_wait = resp_wait - 1;
        end else begin
          periph_r_valid = 1'b1;
          periph_r_rdata = resp_rd_q.pop_front() ? (resp_addr_q[0] ^ PERIPH_KEY) : '0;
          void'(resp_addr_q.pop_front());
          resp_wait = $urandom_range(3, 0);
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (core_local && core_gnt) |=> core_r_valid)
    else fail_now("Local access response did not come one cycle after its grant");

  assert property (@(posedge clk) disable iff (reset)
    perf[PERF_TCDM_CONT] == (dma_busy && core_tcdm))
    else fail_now("TCDM contention pulse does not match the busy stall");

  initial begin
    logic [31:0] addr;
    logic        rd;
    int          n;
    void'($urandom(47));
    reset = 1'b1;
    core_req = 1'b0;
    core_add = '0;
    core_wen = 1'b0;
    core_wdata = '0;
    core_be = '0;
    periph_gnt = 1'b0;
    periph_r_valid = 1'b0;
    periph_r_rdata = '0;
    dma_busy = 1'b0;
    evt = '0;
    eu_mask = '0;
    eu_buf = '0;
    gnt_wait = 0;
    resp_wait = 0;
    periph_waiting = 1'b0;
    cycles = 0;
    ld_pulses = 0;
    st_pulses = 0;
    ld_grants = 0;
    st_grants = 0;
    cont_pulses = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    check_eq("core_gnt_o", 32'(core_gnt), 32'h0);
    check_eq("core_r_valid_o", 32'(core_r_valid), 32'h0);
    check_eq("periph_req_o", 32'(periph_req), 32'h0);
    check_eq("evt_pending_o", 32'(evt_pending), 32'h0);
    check_eq("perf_counters_o", 32'(perf), 32'h0);
    reset = 1'b0;
    @(negedge clk);

    // Merged byte writes seen through both windows and through the wrapped index
    issue(ALIAS_BASE + 32'h40, 1'b0, 32'h1122_3344, 4'hF);
    issue(OWN_BASE + 32'h40, 1'b0, 32'hAABB_CCDD, 4'h5);
    issue(ALIAS_BASE + 32'h40, 1'b1, '0, 4'hF);
    issue(OWN_BASE + 32'h40, 1'b1, '0, 4'hF);
    issue(ALIAS_BASE + 32'h40 + 32'(TCDM_DEPTH * 4), 1'b1, '0, 4'hF);
    wait_idle();
    for (n = 0; n < FILL_WORDS; n++) begin
      issue(ALIAS_BASE + 32'(n * 4), 1'b0, fill_word(ALIAS_BASE + 32'(n * 4)), 4'hF);
    end
    wait_idle();

    issue(ALIAS_BASE + EU_BASE + 32'h00, 1'b0, 32'h0F, 4'hF);
    issue(ALIAS_BASE + EU_BASE + 32'h08, 1'b0, 32'h31, 4'hF);
    issue(OWN_BASE + EU_BASE + 32'h04, 1'b1, '0, 4'hF);
    issue(OWN_BASE + EU_BASE + 32'h10, 1'b1, '0, 4'hF);
    wait_idle();
    check_pending();
    issue(ALIAS_BASE + EU_BASE + 32'h0C, 1'b0, 32'h01, 4'hF);
    wait_idle();
    check_pending();
    evt = 8'h82;
    eu_buf = eu_buf | 8'h82;
    @(negedge clk);
    evt = 8'h00;
    issue(ALIAS_BASE + EU_BASE + 32'h04, 1'b1, '0, 4'hF);
    issue(ALIAS_BASE + EU_BASE + 32'h00, 1'b0, 32'h80, 4'hF);
    issue(ALIAS_BASE + EU_BASE + 32'h10, 1'b1, '0, 4'hF);
    issue(ALIAS_BASE + EU_BASE + 32'h14, 1'b1, '0, 4'hF);
    wait_idle();
    check_pending();

    issue(32'h2000_1230, 1'b1, '0, 4'hF);
    issue(32'h3000_0008, 1'b0, 32'hDEAD_BEEF, 4'h3);
    issue(ALIAS_BASE + 32'h0030_0000, 1'b1, '0, 4'hF);
    issue(OWN_BASE + 32'h0020_0000, 1'b0, 32'h0BAD_F00D, 4'hC);
    issue(32'h10C0_0010, 1'b1, '0, 4'hF);
    wait_idle();

    // Another master holds the scratchpad for four cycles
    dma_busy = 1'b1;
    fork
      issue(ALIAS_BASE + 32'h40, 1'b1, '0, 4'hF);
      begin
        repeat (4) @(negedge clk);
        dma_busy = 1'b0;
      end
    join
    wait_idle();
    check_eq("PERF_TCDM_CONT pulse count", 32'(cont_pulses), 32'd4);

    for (n = 0; n < N_RANDOM; n++) begin
      rd = ($urandom_range(1, 0) == 1);
      case ($urandom_range(2, 0))
        0: addr = (n % 2 == 1 ? OWN_BASE : ALIAS_BASE) +
                  32'(4 * $urandom_range(FILL_WORDS - 1, 0));
        1: addr = ALIAS_BASE + EU_BASE + 32'(4 * $urandom_range(4, 0));
        default: addr = 32'h2000_0000 | ($urandom & 32'h00FF_FFFC);
      endcase
      issue(addr, rd, $urandom, 4'($urandom_range(15, 1)));
    end
    wait_idle();
    check_pending();
    check_eq("PERF_L2_LD pulse count", 32'(ld_pulses), 32'(ld_grants));
    check_eq("PERF_L2_ST pulse count", 32'(st_pulses), 32'(st_grants));

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/cluster_bus_pkg.sv
rtl/cluster_perf_pkg.sv
rtl/core_data_if.sv
rtl/core_demux.sv
rtl/cluster_core_assist.sv
rtl/tcdm_scratchpad.sv
rtl/event_unit_regs.sv
rtl/cluster_data_top.sv
tb/tb_cluster_data_top.sv
